// File: Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - source
    files:
      - source/lsu_pkg.sv
      - source/lsu_stage_if.sv
      - source/lsu_lane_steer.sv
      - source/lsu_bus_fsm.sv
      - source/lsu_data_ram.sv
      - source/lsu_load_align.sv
      - source/lsu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/lsu_checker.sv
      - verif/lsu_tb.sv

// File: compile.f
+incdir+source
source/lsu_pkg.sv
source/lsu_stage_if.sv
source/lsu_lane_steer.sv
source/lsu_bus_fsm.sv
source/lsu_data_ram.sv
source/lsu_load_align.sv
source/lsu_top.sv
verif/lsu_checker.sv
verif/lsu_tb.sv

// File: source/lsu_bus_fsm.sv
//////////////////////////////////////////////////
// Single-beat Wishbone data master, no bursts, no retry.
// Err ends a cycle like ack. A busy bus is not
// back-pressured here: the pipeline must stall stores
//////////////////////////////////////////////////

`include "lsu_cfg.svh"

module lsu_bus_fsm (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              stall_x_i,
    input  logic              stall_m_i,
    input  logic              kill_m_i,
    input  logic              load_q_x_i,
    input  logic              load_q_m_i,
    input  logic              store_q_m_i,
    input  logic              bus_sel_x_i,       // X access is off-chip
    input  lsu_pkg::word_t    address_m_i,
    input  logic              d_ack_i,
    input  logic              d_err_i,
    input  lsu_pkg::word_t    d_dat_i,
    lsu_stage_if.bus          stage,
    output lsu_pkg::word_t    bus_data_m_o,      // Read data for M
    output lsu_pkg::word_t    d_dat_o,
    output lsu_pkg::word_t    d_adr_o,
    output lsu_pkg::byte_en_t d_sel_o,
    output logic              d_cyc_o,
    output logic              d_stb_o,
    output logic              d_we_o,
    output logic              stall_wb_load_o
);
    import lsu_pkg::*;

    bus_state_e state_q;
    logic       load_done_q;                     // Read returned for access in M
    logic       launch_store;
    logic       launch_load;
    logic       bus_done;

    // Strobe tracks cycle, single beat only
    assign d_cyc_o  = (state_q != BUS_IDLE);
    assign d_stb_o  = d_cyc_o;
    assign d_we_o   = (state_q == BUS_STORE);
    assign bus_done = d_cyc_o && (d_ack_i || d_err_i);

    // Store goes out as it leaves M
    assign launch_store = (state_q == BUS_IDLE) && store_q_m_i && !stall_m_i
                          && !stage.ram_sel_m;
    // Load waits in M, pipeline held by stall_wb_load_o
    assign launch_load  = (state_q == BUS_IDLE) && !launch_store && load_q_m_i
                          && stage.bus_sel_m && !load_done_q;

    //////////////////////////////////////////////////
    // Control state
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            state_q         <= BUS_IDLE;
            load_done_q     <= 1'b0;
            stall_wb_load_o <= 1'b0;
        end
        else
        begin
            case (state_q)
                BUS_IDLE:
                begin
                    if (launch_store)
                        state_q <= BUS_STORE;
                    else if (launch_load)
                        state_q <= BUS_LOAD;
                end
                default:                         // Wait for slave
                begin
                    if (bus_done)
                        state_q <= BUS_IDLE;
                end
            endcase
            if (bus_done && (state_q == BUS_LOAD))
                load_done_q <= 1'b1;             // Stores never set it
            if (!stall_m_i)
                load_done_q <= 1'b0;             // Access moved on
            if (bus_done && (state_q == BUS_LOAD))
                stall_wb_load_o <= 1'b0;         // Data is in, release
            if (load_q_x_i && bus_sel_x_i && !stall_x_i)
                stall_wb_load_o <= 1'b1;         // Bus load entering M
            if (kill_m_i)
                stall_wb_load_o <= 1'b0;         // Killed load, drop request
        end
    end

    // Bus payload, held for the whole cycle
    always_ff @(posedge clk_i)
    begin
        if (launch_store || launch_load)
        begin
            d_adr_o <= address_m_i;
            d_sel_o <= stage.byte_en_m;
            d_dat_o <= stage.store_data_m;       // Don't care on reads
        end
        if (bus_done && (state_q == BUS_LOAD))
            bus_data_m_o <= d_dat_i;
    end

endmodule

// File: source/lsu_cfg.svh
//////////////////////////////////////////////////
// LSU build constants. Byte lane logic assumes 4 lanes of 8 bits
// The RAM window base must be aligned to the window size
//////////////////////////////////////////////////

`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Datapath
`define LSU_WORD_W    32              // Data and address width
`define LSU_BYTES     4               // Byte lanes per word

// Local data RAM window, inclusive byte addresses
`define LSU_RAM_BASE  32'h0000_0000
`define LSU_RAM_LIMIT 32'h0000_03FF
`define LSU_RAM_WORDS 256             // Must cover LIMIT - BASE + 1 bytes

`endif

// File: source/lsu_data_ram.sv
//////////////////////////////////////////////////
// Local data RAM, read in X, merged write in M.
// Store then access of the same word back to back
// sees the word from before the store
//////////////////////////////////////////////////

`include "lsu_cfg.svh"

module lsu_data_ram (
    input  logic           clk_i,
    input  logic           stall_x_i,
    input  logic           stall_m_i,
    input  logic           store_q_m_i,
    input  lsu_pkg::word_t address_x_i,
    input  lsu_pkg::word_t address_m_i,
    lsu_stage_if.ram       stage,
    output lsu_pkg::word_t ram_data_m_o        // Word read for access in M
);
    import lsu_pkg::*;

    localparam int ADDR_W = $clog2(`LSU_RAM_WORDS);

    word_t mem [`LSU_RAM_WORDS];
    word_t merged_m;
    logic  in_window_m;

    // M address decoded again, stage view carries no RAM select here
    assign in_window_m = (address_m_i >= `LSU_RAM_BASE) && (address_m_i <= `LSU_RAM_LIMIT);

    // Enabled lanes from store, rest from word read in X
    always_comb
    begin
        for (int k = 0; k < `LSU_BYTES; k++)
            merged_m[8*k +: 8] = stage.byte_en_m[k] ? stage.store_data_m[8*k +: 8]
                                                   : ram_data_m_o[8*k +: 8];
    end

    always_ff @(posedge clk_i)
    begin
        if (!stall_x_i)
            ram_data_m_o <= mem[address_x_i[ADDR_W+1:2]];       // Registered read
        if (store_q_m_i && !stall_m_i && in_window_m)
            mem[address_m_i[ADDR_W+1:2]] <= merged_m;
    end

endmodule

// File: source/lsu_lane_steer.sv
//////////////////////////////////////////////////
// X stage store steering, byte enables and decode.
// Misaligned sizes are not trapped here
//////////////////////////////////////////////////

`include "lsu_cfg.svh"

module lsu_lane_steer (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  stall_m_i,
    input  lsu_pkg::access_size_e size_x_i,
    input  logic                  sign_extend_x_i,
    input  lsu_pkg::word_t        address_x_i,
    input  lsu_pkg::word_t        store_operand_x_i,
    output logic                  bus_sel_x_o,      // To stall request logic
    lsu_stage_if.steer            stage
);
    import lsu_pkg::*;

    word_t    store_data_x;
    byte_en_t byte_en_x;
    logic     ram_sel_x;

    // Replicate operand so every lane carries it
    always_comb
    begin
        case (size_x_i)
            SIZE_BYTE:  store_data_x = {4{store_operand_x_i[7:0]}};
            SIZE_HWORD: store_data_x = {2{store_operand_x_i[15:0]}};
            default:    store_data_x = store_operand_x_i;   // Word
        endcase
    end

    // Big-endian lanes, address 0 is bit 3
    always_comb
    begin
        case (size_x_i)
            SIZE_BYTE:
            begin
                case (address_x_i[1:0])
                    2'b00:   byte_en_x = 4'b1000;
                    2'b01:   byte_en_x = 4'b0100;
                    2'b10:   byte_en_x = 4'b0010;
                    default: byte_en_x = 4'b0001;
                endcase
            end
            SIZE_HWORD: byte_en_x = address_x_i[1] ? 4'b0011 : 4'b1100;
            SIZE_WORD:  byte_en_x = 4'b1111;
            default:    byte_en_x = '0;             // Unused encoding
        endcase
    end

    // Inside the window goes to RAM, everything else to the bus
    assign ram_sel_x   = (address_x_i >= `LSU_RAM_BASE) && (address_x_i <= `LSU_RAM_LIMIT);
    assign bus_sel_x_o = !ram_sel_x;

    //////////////////////////////////////////////////
    // X/M register
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            stage.size_m        <= SIZE_BYTE;
            stage.sign_extend_m <= 1'b0;
            stage.byte_en_m     <= '0;
            stage.ram_sel_m     <= 1'b0;
            stage.bus_sel_m     <= 1'b0;
        end
        else if (!stall_m_i)
        begin
            stage.size_m        <= size_x_i;
            stage.sign_extend_m <= sign_extend_x_i;
            stage.byte_en_m     <= byte_en_x;
            stage.ram_sel_m     <= ram_sel_x;
            stage.bus_sel_m     <= bus_sel_x_o;
        end
    end

    // Store payload
    always_ff @(posedge clk_i)
    begin
        if (!stall_m_i)
            stage.store_data_m <= store_data_x;
    end

endmodule

// File: source/lsu_load_align.sv
//////////////////////////////////////////////////
// M source select, M/W register and load extraction.
// Result is valid one cycle after the load leaves M
//////////////////////////////////////////////////

`include "lsu_cfg.svh"

module lsu_load_align (
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic [1:0]     address_w_i,        // Low address bits in W
    input  lsu_pkg::word_t ram_data_m_i,
    input  lsu_pkg::word_t bus_data_m_i,
    lsu_stage_if.align     stage,
    output lsu_pkg::word_t load_data_o
);
    import lsu_pkg::*;

    access_size_e size_w;
    logic         sign_extend_w;
    word_t        data_w;
    logic [7:0]   byte_w;
    logic [15:0]  half_w;

    // M/W control, loaded every cycle
    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            size_w        <= SIZE_BYTE;
            sign_extend_w <= 1'b0;
        end
        else
        begin
            size_w        <= stage.size_m;
            sign_extend_w <= stage.sign_extend_m;
        end
    end

    // Word from whichever source served M
    always_ff @(posedge clk_i)
        data_w <= stage.bus_sel_m ? bus_data_m_i : ram_data_m_i;

    // Address 0 is the top byte
    always_comb
    begin
        case (address_w_i)
            2'b00:   byte_w = data_w[31:24];
            2'b01:   byte_w = data_w[23:16];
            2'b10:   byte_w = data_w[15:8];
            default: byte_w = data_w[7:0];
        endcase
        half_w = address_w_i[1] ? data_w[15:0] : data_w[31:16];
        case (size_w)
            SIZE_BYTE:  load_data_o = {{24{sign_extend_w & byte_w[7]}}, byte_w};
            SIZE_HWORD: load_data_o = {{16{sign_extend_w & half_w[15]}}, half_w};
            default:    load_data_o = data_w;           // Word passes through
        endcase
    end

endmodule

// File: source/lsu_pkg.sv
//////////////////////////////////////////////////
// Shared LSU types. Size encoding matches the decoder
// of the pipeline: 0 byte, 2 word, 3 halfword
//////////////////////////////////////////////////

`include "lsu_cfg.svh"

package lsu_pkg;

    // Data or address word
    typedef logic [`LSU_WORD_W-1:0] word_t;

    // Lane enable, bit 3 is lane 0 (bits 31:24, big-endian)
    typedef logic [`LSU_BYTES-1:0] byte_en_t;

    // Access size as decoded in X
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd2,
        SIZE_HWORD = 2'd3
    } access_size_e;

    // Data bus master state
    typedef enum logic [1:0] {
        BUS_IDLE,                         // No cycle on the bus
        BUS_STORE,                        // Write cycle, waiting for ack/err
        BUS_LOAD                          // Read cycle, waiting for ack/err
    } bus_state_e;

endpackage

// File: source/lsu_stage_if.sv
//////////////////////////////////////////////////
// M-stage access attributes, levels only.
// Values change on edges with stall_m low
//////////////////////////////////////////////////

interface lsu_stage_if;
    import lsu_pkg::*;

    access_size_e size_m;                 // Size of access in M
    logic         sign_extend_m;          // Load sign extends
    byte_en_t     byte_en_m;              // Lane enables
    word_t        store_data_m;           // Store data, already lane steered
    logic         ram_sel_m;              // Access hits local RAM window
    logic         bus_sel_m;              // Access goes out on data bus

    // Steering stage owns the X/M register
    modport steer (output size_m, sign_extend_m, byte_en_m, store_data_m,
                   ram_sel_m, bus_sel_m);

    // Bus master and local RAM consume the store side
    modport bus   (input byte_en_m, store_data_m, ram_sel_m, bus_sel_m);
    modport ram   (input byte_en_m, store_data_m);

    // Load alignment needs the load side
    modport align (input size_m, sign_extend_m, bus_sel_m);

endinterface

// File: source/lsu_top.sv
//////////////////////////////////////////////////
// Data-side load/store unit. Pipeline must obey the
// stall contract on stall_wb_load_o and busy bus stores
//////////////////////////////////////////////////

`include "lsu_cfg.svh"

module lsu_top (
    input  logic                  clk_i,
    input  logic                  reset_i,
    // Pipeline
    input  logic                  stall_x_i,
    input  logic                  stall_m_i,
    input  logic                  kill_m_i,
    input  logic                  load_q_x_i,
    input  logic                  load_q_m_i,
    input  logic                  store_q_m_i,
    input  logic                  sign_extend_x_i,
    input  lsu_pkg::access_size_e size_x_i,
    input  lsu_pkg::word_t        address_x_i,
    input  lsu_pkg::word_t        address_m_i,
    input  logic [1:0]            address_w_i,
    input  lsu_pkg::word_t        store_operand_x_i,
    output lsu_pkg::word_t        load_data_o,
    output logic                  stall_wb_load_o,
    // Wishbone data bus
    input  lsu_pkg::word_t        d_dat_i,
    input  logic                  d_ack_i,
    input  logic                  d_err_i,
    output lsu_pkg::word_t        d_dat_o,
    output lsu_pkg::word_t        d_adr_o,
    output lsu_pkg::byte_en_t     d_sel_o,
    output logic                  d_cyc_o,
    output logic                  d_stb_o,
    output logic                  d_we_o
);
    import lsu_pkg::*;

    lsu_stage_if stage_if ();                       // M attributes

    logic  bus_sel_x;
    word_t bus_data_m;
    word_t ram_data_m;

    lsu_lane_steer u_steer (
        .clk_i, .reset_i, .stall_m_i, .size_x_i, .sign_extend_x_i,
        .address_x_i, .store_operand_x_i,
        .bus_sel_x_o (bus_sel_x),
        .stage       (stage_if.steer)
    );

    lsu_bus_fsm u_bus (
        .clk_i, .reset_i, .stall_x_i, .stall_m_i, .kill_m_i,
        .load_q_x_i, .load_q_m_i, .store_q_m_i,
        .bus_sel_x_i  (bus_sel_x),
        .address_m_i, .d_ack_i, .d_err_i, .d_dat_i,
        .stage        (stage_if.bus),
        .bus_data_m_o (bus_data_m),
        .d_dat_o, .d_adr_o, .d_sel_o, .d_cyc_o, .d_stb_o, .d_we_o,
        .stall_wb_load_o
    );

    lsu_data_ram u_ram (
        .clk_i, .stall_x_i, .stall_m_i, .store_q_m_i, .address_x_i, .address_m_i,
        .stage        (stage_if.ram),
        .ram_data_m_o (ram_data_m)
    );

    lsu_load_align u_align (
        .clk_i, .reset_i, .address_w_i,
        .ram_data_m_i (ram_data_m),
        .bus_data_m_i (bus_data_m),
        .stage        (stage_if.align),
        .load_data_o
    );

endmodule

// File: verif/lsu_checker.sv
//////////////////////////////////////////////////
// Bus protocol, reset and alignment assertions.
// Bound into every lsu_top instance
//////////////////////////////////////////////////

module lsu_checker (
    input logic                  clk_i,
    input logic                  reset_i,
    input logic                  d_cyc_o,
    input logic                  d_stb_o,
    input logic                  d_we_o,
    input logic                  d_ack_i,
    input logic                  d_err_i,
    input logic                  stall_wb_load_o,
    input logic                  stall_m_i,
    input logic                  kill_m_i,
    input logic                  load_q_m_i,
    input logic                  store_q_m_i,
    input lsu_pkg::word_t        d_adr_o,
    input lsu_pkg::word_t        d_dat_o,
    input lsu_pkg::word_t        address_m_i,
    input lsu_pkg::byte_en_t     d_sel_o,
    input lsu_pkg::access_size_e size_m_i     // From the X/M register
);
    import lsu_pkg::*;

    int unsigned fail_count = 0;
    logic        leaving_m;

    assign leaving_m = (load_q_m_i || store_q_m_i) && !stall_m_i && !kill_m_i;

    // Cycle and strobe drop together after the answering edge
    drop_on_answer: assert property (@(posedge clk_i) disable iff (reset_i)
        (d_cyc_o && (d_ack_i || d_err_i)) |=> (!d_cyc_o && !d_stb_o))
        else begin $error("cyc or stb held after ack"); fail_count++; end

    // Request held until the slave answers
    held_until_ack: assert property (@(posedge clk_i) disable iff (reset_i)
        (d_cyc_o && !d_ack_i && !d_err_i) |=>
        ($stable(d_adr_o) && $stable(d_sel_o) && $stable(d_we_o) && $stable(d_dat_o)))
        else begin $error("bus request changed before ack"); fail_count++; end

    quiet_after_reset: assert property (@(posedge clk_i)
        reset_i |=> (!d_cyc_o && !d_stb_o && !d_we_o && !stall_wb_load_o))
        else begin $error("outputs active after reset"); fail_count++; end

    aligned_in_m: assert property (@(posedge clk_i) disable iff (reset_i)
        leaving_m |-> ((size_m_i == SIZE_BYTE)
                       || (size_m_i == SIZE_WORD && address_m_i[1:0] == 2'b00)
                       || (size_m_i == SIZE_HWORD && !address_m_i[0])))
        else begin $error("misaligned access left M"); fail_count++; end

endmodule

bind lsu_top lsu_checker chk (
    .clk_i, .reset_i, .d_cyc_o, .d_stb_o, .d_we_o, .d_ack_i, .d_err_i,
    .stall_wb_load_o, .stall_m_i, .kill_m_i, .load_q_m_i, .store_q_m_i,
    .d_adr_o, .d_dat_o, .address_m_i, .d_sel_o,
    .size_m_i (stage_if.size_m)
);

// File: verif/lsu_tb.sv
//////////////////////////////////////////////////
// LSU testbench, one access at a time through X, M, W.
// Vectors come from verif/lsu_vectors.txt relative to the project root
// Bus slave adds 0 to 3 wait states and errs at one fixed address
//////////////////////////////////////////////////

`include "lsu_cfg.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam word_t ERR_ADDR = 32'hFFFF_FFF0;    // Slave answers with err here

    logic         clk_i;
    logic         reset_i;
    logic         stall_x_i;
    logic         stall_m_i;
    logic         kill_m_i;
    logic         load_q_x_i;
    logic         load_q_m_i;
    logic         store_q_m_i;
    logic         sign_extend_x_i;
    access_size_e size_x_i;
    word_t        address_x_i;
    word_t        address_m_i;
    logic [1:0]   address_w_i;
    word_t        store_operand_x_i;
    word_t        load_data_o;
    logic         stall_wb_load_o;
    word_t        d_dat_i;
    logic         d_ack_i;
    logic         d_err_i;
    word_t        d_dat_o;
    word_t        d_adr_o;
    byte_en_t     d_sel_o;
    logic         d_cyc_o;
    logic         d_stb_o;
    logic         d_we_o;

    // Vector columns
    byte          ops[$];
    access_size_e sizes[$];
    logic         signs[$];
    word_t        addrs[$];
    word_t        opnds[$];
    word_t        expects[$];

    word_t        slave_mem [word_t];               // Sparse and word addressed
    int unsigned  lcg_state = 41;
    int unsigned  wait_left;
    logic         slave_busy;
    int unsigned  cycle_count = 0;
    int unsigned  cycle_limit = 0;                  // Zero until vectors are known

    lsu_top uut (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Failure and compare helpers
    //////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
            fail_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_sel(input string name, input byte_en_t expected, input byte_en_t actual);
        if (actual !== expected)
            fail_run($sformatf("mismatch %s expected %b actual %b", name, expected, actual));
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            fail_run($sformatf("mismatch %s expected %b actual %b", name, expected, actual));
    endtask

    // Lane 0 is the top byte so the enable shifts down by the offset
    function automatic byte_en_t lane_enables(input access_size_e size, input logic [1:0] low);
        case (size)
            SIZE_BYTE:  return 4'b1000 >> low;
            SIZE_HWORD: return 4'b1100 >> {low[1], 1'b0};
            default:    return 4'b1111;
        endcase
    endfunction

    // Every lane repeats the operand byte at its offset within the access
    function automatic word_t replicate_operand(input access_size_e size, input word_t opnd);
        int    n;
        word_t r;
        n = (size == SIZE_BYTE) ? 1 : (size == SIZE_HWORD) ? 2 : 4;    // Bytes per access
        for (int k = 0; k < `LSU_BYTES; k++)
            r[8*k +: 8] = opnd[8*(k % n) +: 8];
        return r;
    endfunction

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // Unwritten slave words
    function automatic word_t fill_word(input word_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5A5A_5A5A;
    endfunction

    //////////////////////////////////////////////////
    // Bus slave
    //////////////////////////////////////////////////

    task automatic serve_bus_beat();
        word_t key;
        word_t cur;
        key = {d_adr_o[31:2], 2'b00};
        if (d_adr_o == ERR_ADDR)
        begin
            d_err_i <= 1'b1;
            d_dat_i <= '0;                          // Read data is zero on err
        end
        else
        begin
            cur = slave_mem.exists(key) ? slave_mem[key] : fill_word(key);
            if (d_we_o)
            begin
                for (int k = 0; k < `LSU_BYTES; k++)
                    if (d_sel_o[k])
                        cur[8*k +: 8] = d_dat_o[8*k +: 8];
                slave_mem[key] = cur;
            end
            d_dat_i <= cur;
            d_ack_i <= 1'b1;
        end
    endtask

    always @(posedge clk_i)
    begin
        if (reset_i)
        begin
            d_ack_i    <= 1'b0;
            d_err_i    <= 1'b0;
            slave_busy = 1'b0;
        end
        else if (d_cyc_o && !d_ack_i && !d_err_i)
        begin
            if (!slave_busy)
            begin
                slave_busy = 1'b1;
                wait_left  = next_rand() % 4;       // Pick wait states for a new cycle
            end
            if (wait_left == 0)
            begin
                slave_busy = 1'b0;
                serve_bus_beat();
            end
            else
                wait_left--;
        end
        else
        begin
            d_ack_i <= 1'b0;                        // Single beat drops after one edge
            d_err_i <= 1'b0;
        end
    end

    always @(posedge clk_i)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit)
            fail_run("timeout: access never completed");
    end

    // Checker assertions end the run at their first failure
    always @(negedge clk_i)
    begin
        if (uut.chk.fail_count != 0)
            fail_run("a bus or alignment assertion failed");
    end

    //////////////////////////////////////////////////
    // Pipeline model
    //////////////////////////////////////////////////

    task automatic load_vectors();
        int    fd;
        int    got;
        string line;
        byte   op;
        int    size_v;
        int    sign_v;
        word_t a;
        word_t d;
        word_t e;
        fd = $fopen("verif/lsu_vectors.txt", "r");
        if (fd == 0)
            fail_run("could not open the vector file verif/lsu_vectors.txt");
        while (!$feof(fd))
        begin
            line = "";
            got  = $fgets(line, fd);
            if (got > 0 && line.len() > 1 && line[0] != "#")    // Skip comments and blanks
            begin
                got = $sscanf(line, "%c %d %d %h %h %h", op, size_v, sign_v, a, d, e);
                if (got == 6)
                begin
                    ops.push_back(op);
                    sizes.push_back(access_size_e'(size_v));
                    signs.push_back(sign_v[0]);
                    addrs.push_back(a);
                    opnds.push_back(d);
                    expects.push_back(e);
                end
            end
        end
        $fclose(fd);
        if (ops.size() == 0)
            fail_run("the vector file holds no accesses");
    endtask

    task automatic issue_x(input int i);
        @(posedge clk_i);
        load_q_x_i        <= (ops[i] != "S");
        size_x_i          <= sizes[i];
        sign_extend_x_i   <= signs[i];
        address_x_i       <= addrs[i];
        store_operand_x_i <= opnds[i];
    endtask

    // Bus loads stall at once as stall_wb_load_o rises on this edge
    task automatic enter_m(input int i, input logic to_bus);
        @(posedge clk_i);
        load_q_x_i  <= 1'b0;
        address_x_i <= '0;
        address_m_i <= addrs[i];
        address_w_i <= addrs[i][1:0];
        load_q_m_i  <= (ops[i] != "S");
        store_q_m_i <= (ops[i] == "S");
        if (to_bus && ops[i] != "S")
        begin
            stall_x_i <= 1'b1;
            stall_m_i <= 1'b1;
        end
    endtask

    task automatic wait_bus_idle();
        while (d_cyc_o)
            @(negedge clk_i);
    endtask

    task automatic retire_ram_store(input string tag);
        @(posedge clk_i);
        store_q_m_i <= 1'b0;                        // RAM written on this edge
        @(negedge clk_i);
        check_flag({tag, " no bus cycle"}, 1'b0, d_cyc_o);
    endtask

    task automatic retire_ram_load(input int i, input string tag);
        @(posedge clk_i);
        load_q_m_i <= 1'b0;
        @(negedge clk_i);
        check_word({tag, " load data"}, expects[i], load_data_o);
    endtask

    task automatic drain_bus_store(input int i, input string tag);
        @(posedge clk_i);
        store_q_m_i <= 1'b0;                        // Write cycle launched here
        @(negedge clk_i);
        check_flag({tag, " cyc"}, 1'b1, d_cyc_o);
        check_flag({tag, " stb"}, 1'b1, d_stb_o);
        check_flag({tag, " we"}, 1'b1, d_we_o);
        check_word({tag, " address"}, addrs[i], d_adr_o);
        check_sel({tag, " sel"}, lane_enables(sizes[i], addrs[i][1:0]), d_sel_o);
        check_word({tag, " write data"}, replicate_operand(sizes[i], opnds[i]), d_dat_o);
        wait_bus_idle();
    endtask

    task automatic await_bus_load(input int i, input string tag);
        logic ack_seen;
        ack_seen = 1'b0;
        @(negedge clk_i);
        while (stall_wb_load_o)
        begin
            ack_seen = d_ack_i || d_err_i;          // Ack or err in the cycle before release
            if (d_cyc_o)
            begin
                check_flag({tag, " read we"}, 1'b0, d_we_o);
                check_word({tag, " read address"}, addrs[i], d_adr_o);
            end
            @(negedge clk_i);
        end
        check_flag({tag, " ack before stall release"}, 1'b1, ack_seen);
        @(posedge clk_i);
        stall_x_i <= 1'b0;
        stall_m_i <= 1'b0;
        @(posedge clk_i);
        load_q_m_i <= 1'b0;                         // Load has left M
        @(negedge clk_i);
        check_word({tag, " load data"}, expects[i], load_data_o);
    endtask

    task automatic kill_bus_load(input string tag);
        @(negedge clk_i);
        check_flag({tag, " stall raised"}, 1'b1, stall_wb_load_o);
        @(posedge clk_i);
        kill_m_i <= 1'b1;
        @(posedge clk_i);
        kill_m_i   <= 1'b0;
        load_q_m_i <= 1'b0;
        stall_x_i  <= 1'b0;
        stall_m_i  <= 1'b0;
        @(negedge clk_i);
        check_flag({tag, " stall after kill"}, 1'b0, stall_wb_load_o);
        wait_bus_idle();                            // Read still completes on the bus
    endtask

    task automatic run_access(input int i);
        string tag;
        logic  to_bus;
        tag    = $sformatf("vector %0d", i);
        to_bus = !((addrs[i] >= `LSU_RAM_BASE) && (addrs[i] <= `LSU_RAM_LIMIT));
        issue_x(i);
        enter_m(i, to_bus);
        if (ops[i] == "K")
            kill_bus_load(tag);
        else if (ops[i] == "S" && to_bus)
            drain_bus_store(i, tag);
        else if (ops[i] == "S")
            retire_ram_store(tag);
        else if (to_bus)
            await_bus_load(i, tag);
        else
            retire_ram_load(i, tag);
    endtask

    initial
    begin
        reset_i           = 1'b1;
        stall_x_i         = 1'b0;
        stall_m_i         = 1'b0;
        kill_m_i          = 1'b0;
        load_q_x_i        = 1'b0;
        load_q_m_i        = 1'b0;
        store_q_m_i       = 1'b0;
        sign_extend_x_i   = 1'b0;
        size_x_i          = SIZE_WORD;
        address_x_i       = '0;
        address_m_i       = '0;
        address_w_i       = 2'b00;
        store_operand_x_i = '0;
        d_dat_i           = '0;
        d_ack_i           = 1'b0;
        d_err_i           = 1'b0;
        load_vectors();
        cycle_limit = 40 * ops.size() + 10;         // 40 per access plus reset
        repeat (3) @(posedge clk_i);
        reset_i <= 1'b0;
        for (int i = 0; i < ops.size(); i++)
            run_access(i);
        @(negedge clk_i);
        if (uut.chk.fail_count == 0)
        begin
            $display("=== PASS ===");
            $finish;
        end
        else
            fail_run("bus or alignment assertions failed during the run");
    end

endmodule

// File: verif/lsu_vectors.txt
# op: S store, L load, K bus load killed in M; size: 0 byte, 2 word, 3 halfword
# op size sign address operand expected_load (hex, expected is 0 where unused)
S 2 0 00000010 11223344 00000000
S 0 0 00000011 000000AB 00000000
S 3 0 00000012 0000CDEF 00000000
L 2 0 00000010 00000000 11ABCDEF
L 0 0 00000011 00000000 000000AB
L 0 1 00000011 00000000 FFFFFFAB
L 3 1 00000012 00000000 FFFFCDEF
L 3 0 00000012 00000000 0000CDEF
S 2 0 000003FC 80FF7F01 00000000
L 0 1 000003FD 00000000 FFFFFFFF
L 0 1 000003FE 00000000 0000007F
L 3 0 000003FC 00000000 000080FF
S 2 0 00001000 DEADBEEF 00000000
S 0 0 00001001 00000055 00000000
S 3 0 00001002 00001234 00000000
L 2 0 00001000 00000000 DE551234
L 0 1 00001000 00000000 FFFFFFDE
L 3 0 00001002 00000000 00001234
L 2 0 FFFFFFF0 00000000 00000000
K 2 0 00001000 00000000 00000000
L 3 1 00001000 00000000 FFFFDE55
